/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = led_panel_tb
FILELIST = all.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD)

/* all.f */
+incdir+include
hw/panel_pkg.sv
hw/apb_pkg.sv
hw/panel_ifs.sv
hw/scan_timer.sv
hw/apb_pixel_port.sv
hw/frame_compositor.sv
hw/led_panel_top.sv
bench/led_panel_checker.sv
bench/led_panel_tb.sv

/* bench/led_panel_checker.sv */
`default_nettype none

module led_panel_checker (
    input logic clk,
    input logic pll_locked,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic panel_sclk,
    input logic panel_latch,
    input logic panel_blank
);
    timeunit 1ns;
    timeprecision 100ps;

    // rows switch only while the drivers are off
    latch_blanked: assert property (@(posedge clk) disable iff (!pll_locked)
        panel_latch |-> panel_blank)
        else $error("panel_latch high while panel_blank is low");

    sclk_not_in_latch: assert property (@(posedge clk) disable iff (!pll_locked)
        !(panel_sclk && panel_latch))
        else $error("panel_sclk and panel_latch high in the same cycle");

    ready_in_access: assert property (@(posedge clk) disable iff (!pll_locked)
        pready |-> (psel && penable))
        else $error("pready high outside an APB access phase");

    error_on_completion: assert property (@(posedge clk) disable iff (!pll_locked)
        pslverr |-> pready)
        else $error("pslverr high without pready");

endmodule

bind led_panel_top led_panel_checker led_panel_checker_i (
    .clk         (clk),
    .pll_locked  (pll_locked),
    .psel        (psel),
    .penable     (penable),
    .pready      (pready),
    .pslverr     (pslverr),
    .panel_sclk  (panel_sclk),
    .panel_latch (panel_latch),
    .panel_blank (panel_blank)
);

`default_nettype wire

/* bench/led_panel_tb.sv */
`default_nettype none
`include "panel_settings.svh"

module led_panel_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROW_CYCLES  = `PANEL_COLS * 2 + `LATCH_CYCLES + `UNBLANK_CYCLES;
    localparam int APB_TIMEOUT = 8;
    localparam int SUBFRAMES   = 2 ** `SUBFRAME_BITS;

    logic                 clk;
    logic                 pll_locked;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    apb_pkg::apb_addr_t   paddr;
    apb_pkg::apb_data_t   pwdata;
    apb_pkg::apb_data_t   prdata;
    logic                 pready;
    logic                 pslverr;
    logic [2:0]           panel_rgb0;
    logic [2:0]           panel_rgb1;
    panel_pkg::row_addr_t panel_addr;
    logic                 panel_sclk;
    logic                 panel_latch;
    logic                 panel_blank;
    logic [31:0]          lcg_state;
    panel_pkg::pixel_t    model [2 ** `PIXEL_ADDR_BITS];   // last value written per address

    led_panel_top led_panel_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // channel padded with zeros at the low end, red 0, green 1, blue 2
    function automatic int widened(input panel_pkg::pixel_t px, input int c);
        case (c)
            0:       return int'(px.red) * 8;
            1:       return int'(px.green) * 4;
            default: return int'(px.blue) * 8;
        endcase
    endfunction

    task automatic compare_pixel(input string name, input panel_pkg::pixel_t got,
                                 input panel_pkg::pixel_t exp);
        if (got !== exp) begin
            $display("FAIL at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_rgb(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0d ns: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_row(input string name, input panel_pkg::row_addr_t got,
                               input panel_pkg::row_addr_t exp);
        if (got !== exp) begin
            $display("FAIL at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL at %0d ns: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // counts access cycles up to and including the one with pready
    task automatic wait_ready(output int cycles);
        cycles = 1;
        @(negedge clk);
        while (!pready) begin
            if (cycles >= APB_TIMEOUT) begin
                $display("timeout: pready never came during an APB transfer");
                abort_run();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic apb_transfer(input logic write, input apb_pkg::apb_addr_t addr,
                                input apb_pkg::apb_data_t wdata,
                                output apb_pkg::apb_data_t rdata, output logic err);
        int cycles;
        @(posedge clk);
        psel    <= 1'b1;        // setup phase
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        wait_ready(cycles);
        rdata = prdata;
        err   = pslverr;
        compare_count(write ? "write access cycles" : "read access cycles", cycles,
                      write ? 1 : 2);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t data,
                             output logic err);
        apb_pkg::apb_data_t ignored;
        apb_transfer(1'b1, addr, data, ignored, err);
    endtask

    task automatic apb_read(input apb_pkg::apb_addr_t addr, output apb_pkg::apb_data_t data,
                            output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    // runs to the next latch, counting sclk edges and keeping colours at edges 11 and 12
    task automatic wait_latch(output int edges, output logic [2:0] top10, output logic [2:0] bot10,
                              output logic [2:0] top11, output logic [2:0] bot11);
        int   cycles;
        logic prev_sclk;
        edges     = 0;
        cycles    = 0;
        prev_sclk = 1'b0;
        top10     = '0;
        bot10     = '0;
        top11     = '0;
        bot11     = '0;
        @(negedge clk);
        while (!panel_latch) begin
            if (panel_sclk && !prev_sclk) begin
                edges++;
                if (edges == 11) begin
                    top10 = panel_rgb0;
                    bot10 = panel_rgb1;
                end
                if (edges == 12) begin
                    top11 = panel_rgb0;
                    bot11 = panel_rgb1;
                end
            end
            prev_sclk = panel_sclk;
            cycles++;
            if (cycles > 2 * ROW_CYCLES) begin
                $display("timeout: panel_latch never came within two row times");
                abort_run();
            end
            @(negedge clk);
        end
    endtask

    task automatic after_reset_state();
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_rgb("panel_rgb0", panel_rgb0, 3'b000);
        compare_rgb("panel_rgb1", panel_rgb1, 3'b000);
        compare_row("panel_addr", panel_addr, '0);
        @(posedge clk);
        pll_locked <= 1'b1;     // third rising edge
        @(negedge clk);
        compare_flag("panel_blank", panel_blank, 1'b1);
        compare_flag("panel_sclk", panel_sclk, 1'b0);
        compare_flag("panel_latch", panel_latch, 1'b0);
        compare_flag("pready", pready, 1'b0);
        compare_flag("pslverr", pslverr, 1'b0);
    endtask

    task automatic readback_random_pixels();
        apb_pkg::apb_addr_t addrs [$];
        apb_pkg::apb_addr_t addr;
        apb_pkg::apb_data_t data;
        logic               err;
        logic [31:0]        r;
        for (int i = 0; i < 16; i++) begin
            r    = lcg_next();
            addr = {1'b0, r[26:16]};
            data = r[15:0];
            apb_write(addr, data, err);
            compare_flag("pslverr", err, 1'b0);
            model[addr[`PIXEL_ADDR_BITS-1:0]] = panel_pkg::pixel_t'(data);
            addrs.push_back(addr);
        end
        foreach (addrs[i]) begin
            apb_read(addrs[i], data, err);
            compare_flag("pslverr", err, 1'b0);
            compare_pixel("prdata", panel_pkg::pixel_t'(data),
                          model[addrs[i][`PIXEL_ADDR_BITS-1:0]]);
        end
    endtask

    task automatic reject_bad_address();
        apb_pkg::apb_data_t data;
        logic               err;
        apb_write(12'h000, 16'hbeef, err);
        compare_flag("pslverr", err, 1'b0);
        apb_write(12'h800, 16'h1234, err);  // would alias address 0 if decoded short
        compare_flag("pslverr", err, 1'b1);
        apb_read(12'hfff, data, err);
        compare_flag("pslverr", err, 1'b1);
        compare_pixel("prdata", panel_pkg::pixel_t'(data), '0);
        apb_read(12'h000, data, err);
        compare_flag("pslverr", err, 1'b0);
        compare_pixel("prdata", panel_pkg::pixel_t'(data), panel_pkg::pixel_t'(16'hbeef));
    endtask

    task automatic scan_row_sequence();
        int         edges;
        int         tries;
        logic [2:0] c0, c1, c2, c3;
        tries = 0;
        wait_latch(edges, c0, c1, c2, c3);      // partial row
        while (panel_addr != '0) begin
            if (tries > `SCAN_ROWS) begin
                $display("panel_addr never showed row 0 at a latch");
                abort_run();
            end
            tries++;
            wait_latch(edges, c0, c1, c2, c3);
        end
        for (int i = 1; i <= `SCAN_ROWS; i++) begin
            wait_latch(edges, c0, c1, c2, c3);
            compare_count("panel_sclk rising edges", edges, `PANEL_COLS);
            compare_row("panel_addr", panel_addr, panel_pkg::row_addr_t'(i % `SCAN_ROWS));
        end
    endtask

    task automatic pwm_duty_counts();
        panel_pkg::pixel_t top_px;
        panel_pkg::pixel_t bot_px;
        int                top_ones [3] = '{0, 0, 0};
        int                bot_ones [3] = '{0, 0, 0};
        int                edges;
        int                seen;
        int                tries;
        logic              err;
        logic [2:0]        top10, bot10, top11, bot11;
        top_px = '{red: 5'h13, green: 6'h2a, blue: 5'h05};
        bot_px = '{red: 5'h06, green: 6'h3f, blue: 5'h1b};
        apb_write(apb_pkg::apb_addr_t'(3 * `PANEL_COLS + 10), top_px, err);
        compare_flag("pslverr", err, 1'b0);
        apb_write(apb_pkg::apb_addr_t'((3 + `SCAN_ROWS) * `PANEL_COLS + 10), bot_px, err);
        compare_flag("pslverr", err, 1'b0);
        // black neighbours in column 11
        apb_write(apb_pkg::apb_addr_t'(3 * `PANEL_COLS + 11), '0, err);
        compare_flag("pslverr", err, 1'b0);
        apb_write(apb_pkg::apb_addr_t'((3 + `SCAN_ROWS) * `PANEL_COLS + 11), '0, err);
        compare_flag("pslverr", err, 1'b0);
        seen  = 0;
        tries = 0;
        wait_latch(edges, top10, bot10, top11, bot11);
        while (seen < SUBFRAMES) begin
            if (tries > (SUBFRAMES + 1) * `SCAN_ROWS) begin
                $display("row 3 was latched fewer than %0d times", SUBFRAMES);
                abort_run();
            end
            tries++;
            wait_latch(edges, top10, bot10, top11, bot11);
            if (panel_addr == panel_pkg::row_addr_t'(3)) begin
                compare_rgb("panel_rgb0 on black pixel", top11, 3'b000);
                compare_rgb("panel_rgb1 on black pixel", bot11, 3'b000);
                for (int c = 0; c < 3; c++) begin
                    top_ones[c] += int'(top10[c]);
                    bot_ones[c] += int'(bot10[c]);
                end
                seen++;
            end
        end
        for (int c = 0; c < 3; c++) begin
            compare_count($sformatf("panel_rgb0[%0d] lit count", c), top_ones[c],
                          widened(top_px, c));
            compare_count($sformatf("panel_rgb1[%0d] lit count", c), bot_ones[c],
                          widened(bot_px, c));
        end
    endtask

    initial begin
        lcg_state  = 32'h772c_9a18;
        pll_locked = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        after_reset_state();
        readback_random_pixels();
        reject_bad_address();
        scan_row_sequence();
        pwm_duty_counts();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/apb_pixel_port.sv */
`default_nettype none
`include "panel_settings.svh"

module apb_pixel_port (
    input  logic               clk,
    input  logic               pll_locked,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  apb_pkg::apb_addr_t paddr,
    input  apb_pkg::apb_data_t pwdata,
    output apb_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    pixel_bus_if.host          pix
);
    apb_pkg::apb_state_e         state;
    apb_pkg::pixel_op_e          op;
    logic                        is_write;
    logic                        is_err;
    logic                        setup;
    logic                        in_range;
    logic [`PIXEL_ADDR_BITS-1:0] addr_q;
    panel_pkg::pixel_t           wdata_q;

    assign setup    = psel && !penable && (state == apb_pkg::idle);
    assign in_range = (paddr[`APB_ADDR_BITS-1:`PIXEL_ADDR_BITS] == '0);

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            state    <= apb_pkg::idle;
            op       <= apb_pkg::op_none;
            is_write <= 1'b0;
            is_err   <= 1'b0;
        end else begin
            op <= apb_pkg::op_none;     // a request lasts one cycle
            case (state)
                apb_pkg::idle: begin
                    if (setup) begin
                        is_write <= pwrite;
                        is_err   <= !in_range;
                        // out of range transfers never reach the store
                        if (in_range) begin
                            op <= pwrite ? apb_pkg::op_write : apb_pkg::op_read;
                        end
                        state <= apb_pkg::access;
                    end
                end
                apb_pkg::access: begin
                    if (psel && penable && !is_write) begin
                        state <= apb_pkg::read_wait;    // store answers next cycle
                    end else begin
                        state <= apb_pkg::idle;
                    end
                end
                apb_pkg::read_wait: begin
                    state <= apb_pkg::idle;
                end
                default: begin
                    state <= apb_pkg::idle;
                end
            endcase
        end
    end

    // request payload, captured in the setup phase
    always_ff @(posedge clk) begin
        if (setup) begin
            addr_q  <= paddr[`PIXEL_ADDR_BITS-1:0];
            wdata_q <= panel_pkg::pixel_t'(pwdata);
        end
    end

    assign pready  = psel && penable &&
                     ((state == apb_pkg::access && is_write) || state == apb_pkg::read_wait);
    assign pslverr = pready && is_err;
    assign prdata  = (pready && !is_write && !is_err) ? apb_pkg::apb_data_t'(pix.rdata) : '0;

    assign pix.op    = op;
    assign pix.addr  = addr_q;
    assign pix.wdata = wdata_q;

endmodule

`default_nettype wire

/* hw/apb_pkg.sv */
`default_nettype none
`include "panel_settings.svh"

package apb_pkg;

    typedef enum logic [1:0] {
        idle,           // waiting for a setup phase
        access,         // first access cycle
        read_wait       // second access cycle of a read
    } apb_state_e;

    // one request per transfer towards the frame store
    typedef enum logic [1:0] {
        op_none,
        op_write,
        op_read
    } pixel_op_e;

    typedef logic [`APB_ADDR_BITS-1:0] apb_addr_t;
    typedef logic [`PIXEL_BITS-1:0]    apb_data_t;

endpackage

`default_nettype wire

/* hw/frame_compositor.sv */
`default_nettype none
`include "panel_settings.svh"

module frame_compositor (
    input  logic                 clk,
    input  logic                 pll_locked,
    scan_if.sink                 scan,
    pixel_bus_if.store           pix,
    output logic [2:0]           panel_rgb0,
    output logic [2:0]           panel_rgb1,
    output panel_pkg::row_addr_t panel_addr,
    output logic                 panel_sclk,
    output logic                 panel_latch,
    output logic                 panel_blank
);
    localparam int BANK_DEPTH = `PANEL_COLS * `SCAN_ROWS;

    panel_pkg::pixel_t          top_bank [BANK_DEPTH];     // rows 0 to 15
    panel_pkg::pixel_t          bot_bank [BANK_DEPTH];     // rows 16 to 31
    logic [`BANK_ADDR_BITS-1:0] host_idx;
    logic                       host_bot;
    logic [`BANK_ADDR_BITS-1:0] scan_idx;
    panel_pkg::subframe_t       sub_rev;
    panel_pkg::pixel_t          top_px;
    panel_pkg::pixel_t          bot_px;
    logic                       shifting;
    logic                       row_shown;  // a row has been latched since reset

    // one bit per channel, {blue, green, red}
    function automatic logic [2:0] pwm_bits(input panel_pkg::pixel_t px,
                                            input panel_pkg::subframe_t cmp);
        return {{px.blue, 3'b000} > cmp, {px.green, 2'b00} > cmp, {px.red, 3'b000} > cmp};
    endfunction

    assign host_bot = pix.addr[`PIXEL_ADDR_BITS-1];
    assign host_idx = pix.addr[`BANK_ADDR_BITS-1:0];
    assign scan_idx = {scan.row_addr, scan.col};

    // reversed so the low PWM weights spread over the subframes
    assign sub_rev = {<<{scan.subframe}};

    assign top_px = top_bank[scan_idx];
    assign bot_px = bot_bank[scan_idx];

    assign shifting = (scan.phase == panel_pkg::shift_low) ||
                      (scan.phase == panel_pkg::shift_high);

    // host port
    always_ff @(posedge clk) begin
        if (pix.op == apb_pkg::op_write) begin
            if (host_bot) begin
                bot_bank[host_idx] <= pix.wdata;
            end else begin
                top_bank[host_idx] <= pix.wdata;
            end
        end
        if (pix.op == apb_pkg::op_read) begin
            pix.rdata <= host_bot ? bot_bank[host_idx] : top_bank[host_idx];
        end
    end

    // panel pins, one cycle behind the scan position
    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            panel_rgb0  <= '0;
            panel_rgb1  <= '0;
            panel_addr  <= '0;
            panel_sclk  <= 1'b0;
            panel_latch <= 1'b0;
            panel_blank <= 1'b1;
            row_shown   <= 1'b0;
        end else begin
            panel_rgb0  <= pwm_bits(top_px, sub_rev);
            panel_rgb1  <= pwm_bits(bot_px, sub_rev);
            panel_sclk  <= (scan.phase == panel_pkg::shift_high);
            panel_latch <= (scan.phase == panel_pkg::latch_row);
            panel_blank <= !row_shown || !shifting;     // dark until the first latch
            // address switches with the latch, while the drivers are off
            if (scan.phase == panel_pkg::latch_row) begin
                row_shown  <= 1'b1;
                panel_addr <= scan.row_addr;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/led_panel_top.sv */
`default_nettype none

module led_panel_top (
    input  logic                 clk,
    input  logic                 pll_locked,
    // apb3 slave
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  apb_pkg::apb_addr_t   paddr,
    input  apb_pkg::apb_data_t   pwdata,
    output apb_pkg::apb_data_t   prdata,
    output logic                 pready,
    output logic                 pslverr,
    // hub75 style panel
    output logic [2:0]           panel_rgb0,    // top half
    output logic [2:0]           panel_rgb1,    // bottom half
    output panel_pkg::row_addr_t panel_addr,
    output logic                 panel_sclk,
    output logic                 panel_latch,
    output logic                 panel_blank
);
    scan_if      scan_bus ();
    pixel_bus_if pix_bus ();

    scan_timer scan_timer_i (
        .clk        (clk),
        .pll_locked (pll_locked),
        .scan       (scan_bus)
    );

    apb_pixel_port apb_pixel_port_i (
        .clk        (clk),
        .pll_locked (pll_locked),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .pix        (pix_bus)
    );

    frame_compositor frame_compositor_i (
        .clk         (clk),
        .pll_locked  (pll_locked),
        .scan        (scan_bus),
        .pix         (pix_bus),
        .panel_rgb0  (panel_rgb0),
        .panel_rgb1  (panel_rgb1),
        .panel_addr  (panel_addr),
        .panel_sclk  (panel_sclk),
        .panel_latch (panel_latch),
        .panel_blank (panel_blank)
    );

endmodule

`default_nettype wire

/* hw/panel_ifs.sv */
`default_nettype none
`include "panel_settings.svh"

// scan position, from the timer to the compositor
interface scan_if;
    panel_pkg::col_t        col;
    panel_pkg::row_addr_t   row_addr;
    panel_pkg::subframe_t   subframe;
    panel_pkg::scan_phase_e phase;

    modport timer (
        output col,
        output row_addr,
        output subframe,
        output phase
    );

    modport sink (
        input col,
        input row_addr,
        input subframe,
        input phase
    );
endinterface

// host access to the frame store
interface pixel_bus_if;
    apb_pkg::pixel_op_e          op;
    logic [`PIXEL_ADDR_BITS-1:0] addr;      // {row, col}, row bit 4 picks the bank
    panel_pkg::pixel_t           wdata;
    panel_pkg::pixel_t           rdata;     // one cycle after op_read

    modport host (
        output op,
        output addr,
        output wdata,
        input  rdata
    );

    modport store (
        input  op,
        input  addr,
        input  wdata,
        output rdata
    );
endinterface

`default_nettype wire

/* hw/panel_pkg.sv */
`default_nettype none
`include "panel_settings.svh"

package panel_pkg;

    // where the scan is within one row
    typedef enum logic [1:0] {
        shift_low,      // column data set up, sclk low
        shift_high,     // sclk rising edge
        latch_row,
        unblank_row
    } scan_phase_e;

    // rgb565, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixel_t;

    typedef logic [$clog2(`PANEL_COLS)-1:0] col_t;
    typedef logic [$clog2(`SCAN_ROWS)-1:0]  row_addr_t;
    typedef logic [`SUBFRAME_BITS-1:0]      subframe_t;

endpackage

`default_nettype wire

/* hw/scan_timer.sv */
`default_nettype none
`include "panel_settings.svh"

module scan_timer (
    input  logic  clk,
    input  logic  pll_locked,
    scan_if.timer scan
);
    panel_pkg::col_t        col;
    panel_pkg::row_addr_t   row_addr;
    panel_pkg::subframe_t   subframe;
    panel_pkg::scan_phase_e phase;
    logic [1:0]             hold;       // cycles already spent in latch or unblank
    logic                   last_col;
    logic                   last_row;

    assign last_col = (col == panel_pkg::col_t'(`PANEL_COLS - 1));
    assign last_row = (row_addr == panel_pkg::row_addr_t'(`SCAN_ROWS - 1));

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            col      <= '0;
            row_addr <= '0;
            subframe <= '0;
            phase    <= panel_pkg::shift_low;
            hold     <= '0;
        end else begin
            case (phase)
                panel_pkg::shift_low: begin
                    phase <= panel_pkg::shift_high;
                end
                panel_pkg::shift_high: begin
                    col <= col + panel_pkg::col_t'(1);     // wraps to 0 after the last slot
                    if (last_col) begin
                        phase <= panel_pkg::latch_row;
                    end else begin
                        phase <= panel_pkg::shift_low;
                    end
                end
                panel_pkg::latch_row: begin
                    if (hold == 2'(`LATCH_CYCLES - 1)) begin
                        hold  <= '0;
                        phase <= panel_pkg::unblank_row;
                    end else begin
                        hold <= hold + 2'd1;
                    end
                end
                panel_pkg::unblank_row: begin
                    if (hold == 2'(`UNBLANK_CYCLES - 1)) begin
                        hold     <= '0;
                        phase    <= panel_pkg::shift_low;
                        row_addr <= row_addr + panel_pkg::row_addr_t'(1);
                        // next subframe once both halves are fully scanned
                        if (last_row) begin
                            subframe <= subframe + panel_pkg::subframe_t'(1);
                        end
                    end else begin
                        hold <= hold + 2'd1;
                    end
                end
                default: begin
                    phase <= panel_pkg::shift_low;
                end
            endcase
        end
    end

    assign scan.col      = col;
    assign scan.row_addr = row_addr;
    assign scan.subframe = subframe;
    assign scan.phase    = phase;

endmodule

`default_nettype wire

/* include/panel_settings.svh */
`ifndef PANEL_SETTINGS_SVH
`define PANEL_SETTINGS_SVH

// panel geometry
`define PANEL_COLS 64
`define PANEL_ROWS 32
`define SCAN_ROWS (`PANEL_ROWS / 2)    // rows r and r+16 share one address

// colour depth and pixel format
`define SUBFRAME_BITS 8
`define PIXEL_BITS 16                  // rgb565

// frame store and host bus addressing
`define PIXEL_ADDR_BITS 11
`define BANK_ADDR_BITS (`PIXEL_ADDR_BITS - 1)
`define APB_ADDR_BITS 12

// scan phase lengths in clk cycles
// each column slot is always one shift_low plus one shift_high cycle
`define LATCH_CYCLES 1
`define UNBLANK_CYCLES 1

`endif
